// File: lsu_top.f
lsu_pkg.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_ctrl_fsm.sv
lsu_top.sv
tb_clk_gen.sv
tb_lsu_top.sv

// File: tb_lsu_top.sv
//////////////////////////////////////////////////////////////////////
// testbench for the load/store unit
// core-side stimulus, bus memory model with random grants and
// response delays, protocol and result checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;

  localparam int N_DIRECTED     = 21;
  localparam int N_RANDOM       = 200;
  localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * 40 + 16; // reset and idle slack

  logic clk;
  logic rst_n;

  // core side
  logic               lsu_req_i;
  logic               lsu_we_i;
  logic               lsu_sign_ext_i;
  lsu_pkg::lsu_type_t lsu_type_i;
  lsu_pkg::lsu_word_t lsu_addr_i;
  lsu_pkg::lsu_word_t lsu_wdata_i;
  lsu_pkg::lsu_word_t lsu_rdata_o;
  logic               lsu_valid_o;
  logic               addr_incr_req_o;
  logic               load_err_o;
  logic               store_err_o;
  logic               busy_o;
  // data bus
  logic               data_req_o;
  logic               data_gnt_i;
  logic               data_rvalid_i;
  logic               data_err_i;
  lsu_pkg::lsu_word_t data_rdata_i;
  logic               data_we_o;
  lsu_pkg::lsu_word_t data_addr_o;
  lsu_pkg::lsu_word_t data_wdata_o;
  lsu_pkg::lsu_be_t   data_be_o;

  logic [7:0] bus_mem [0:16383]; // memory behind the bus with 16 KiB wrap
  logic [7:0] ref_mem [0:16383]; // expected contents updated per store

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  lsu_top dut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .lsu_req_i       (lsu_req_i),
    .lsu_we_i        (lsu_we_i),
    .lsu_sign_ext_i  (lsu_sign_ext_i),
    .lsu_type_i      (lsu_type_i),
    .lsu_addr_i      (lsu_addr_i),
    .lsu_wdata_i     (lsu_wdata_i),
    .lsu_rdata_o     (lsu_rdata_o),
    .lsu_valid_o     (lsu_valid_o),
    .addr_incr_req_o (addr_incr_req_o),
    .load_err_o      (load_err_o),
    .store_err_o     (store_err_o),
    .busy_o          (busy_o),
    .data_req_o      (data_req_o),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_err_i      (data_err_i),
    .data_rdata_i    (data_rdata_i),
    .data_we_o       (data_we_o),
    .data_addr_o     (data_addr_o),
    .data_wdata_o    (data_wdata_o),
    .data_be_o       (data_be_o)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  task automatic value_error(input string msg);
    abort_run($sformatf("ERROR at %0d ns: %s", $time, msg));
  endtask

  function automatic lsu_pkg::lsu_word_t xorshift32(input lsu_pkg::lsu_word_t x);
    lsu_pkg::lsu_word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int access_size(input lsu_pkg::lsu_type_t typ);
    if (typ == lsu_pkg::TYPE_WORD) return 4;
    if (typ == lsu_pkg::TYPE_HALF) return 2;
    return 1;                                   // code 3 counts as byte
  endfunction

  // bytes addr..addr+size-1 of the expected memory with the lowest byte first
  function automatic lsu_pkg::lsu_word_t expected_load(input lsu_pkg::lsu_word_t addr,
                                                       input int size, input logic sign_ext);
    lsu_pkg::lsu_word_t val;
    logic [13:0]        idx;
    int                 k;
    val = '0;
    for (k = 0; k < size; k++) begin
      idx = addr[13:0] + 14'(k);
      val[8*k +: 8] = ref_mem[idx];
    end
    if (sign_ext && size < 4 && val[8*size-1]) begin
      val = val | (32'hffff_ffff << (8 * size)); // copy top bit upward
    end
    return val;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // one core access checked grant by grant
  //////////////////////////////////////////////////////////////////////

  task automatic run_access(input logic we, input lsu_pkg::lsu_type_t typ,
                            input logic sign_ext, input lsu_pkg::lsu_word_t addr,
                            input lsu_pkg::lsu_word_t wdata);
    int                 size;
    int                 grants;
    int                 k;
    int                 l;
    logic               split;
    logic               exp_err;
    logic               exp_incr;
    logic               done;
    logic               first_cycle;
    lsu_pkg::lsu_word_t exp_rdata;
    lsu_pkg::lsu_word_t word_addr;
    lsu_pkg::lsu_word_t byte_addr;
    lsu_pkg::lsu_be_t   exp_be;
    size      = access_size(typ);
    split     = (int'(addr[1:0]) + size) > 4;   // crosses a word boundary
    exp_err   = 1'b0;
    for (k = 0; k < size; k++) begin
      byte_addr = addr + 32'(k);
      exp_err   = exp_err | byte_addr[12];
    end
    exp_rdata = expected_load(addr, size, sign_ext);
    if (we) begin
      for (k = 0; k < size; k++) begin
        ref_mem[addr[13:0] + 14'(k)] = wdata[8*k +: 8];
      end
    end
    lsu_req_i      <= 1'b1;
    lsu_we_i       <= we;
    lsu_type_i     <= typ;
    lsu_sign_ext_i <= sign_ext;
    lsu_addr_i     <= addr;
    lsu_wdata_i    <= wdata;
    grants      = 0;
    done        = 1'b0;
    first_cycle = 1'b1;
    while (!done) begin
      @(posedge clk);
      // idle only in the cycle the request arrives
      assert (busy_o == !first_cycle)
        else value_error($sformatf("busy_o %b, expected %b", busy_o, !first_cycle));
      first_cycle = 1'b0;
      // high from the first grant up to the second grant
      exp_incr = split && (grants == 1);
      assert (addr_incr_req_o == exp_incr)
        else value_error($sformatf("addr_incr_req_o %b, expected %b",
                                   addr_incr_req_o, exp_incr));
      if (data_req_o && data_gnt_i) begin
        word_addr = {addr[31:2], 2'b00} + 32'(4 * grants);
        exp_be    = '0;
        for (l = 0; l < 4; l++) begin
          byte_addr = word_addr + 32'(l);
          if (byte_addr >= addr && byte_addr < addr + 32'(size)) exp_be[l] = 1'b1;
        end
        assert (grants < (split ? 2 : 1))
          else value_error($sformatf("extra bus grant for access at %h", addr));
        assert (data_addr_o == word_addr)
          else value_error($sformatf("data_addr_o %h, expected %h", data_addr_o, word_addr));
        assert (data_be_o == exp_be)
          else value_error($sformatf("data_be_o %b, expected %b", data_be_o, exp_be));
        assert (data_we_o == we)
          else value_error($sformatf("data_we_o %b, expected %b", data_we_o, we));
        for (l = 0; l < 4; l++) begin
          k = int'(word_addr + 32'(l) - addr);  // operand byte for this lane
          if (we && exp_be[l]) begin
            assert (data_wdata_o[8*l +: 8] == wdata[8*k +: 8])
              else value_error($sformatf("data_wdata_o lane %0d is %h, expected %h",
                                         l, data_wdata_o[8*l +: 8], wdata[8*k +: 8]));
          end
        end
        if (split && grants == 0) lsu_addr_i <= addr + 32'd4; // next word for part two
        grants++;
      end
      if (lsu_valid_o) begin
        done = 1'b1;
        lsu_req_i <= 1'b0;
        assert (grants == (split ? 2 : 1))
          else value_error($sformatf("%0d bus grants for access at %h", grants, addr));
        assert (load_err_o == (exp_err && !we))
          else value_error($sformatf("load_err_o %b for access at %h", load_err_o, addr));
        assert (store_err_o == (exp_err && we))
          else value_error($sformatf("store_err_o %b for access at %h", store_err_o, addr));
        if (!we) begin
          assert (lsu_rdata_o == exp_rdata)
            else value_error($sformatf("load at %h returned %h, expected %h",
                                       addr, lsu_rdata_o, exp_rdata));
        end
      end
    end
    @(posedge clk);                              // request low for one cycle
    assert (!lsu_valid_o && !busy_o && !data_req_o && !addr_incr_req_o)
      else value_error("DUT still active in the cycle after the access");
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus memory model
  //////////////////////////////////////////////////////////////////////

  lsu_pkg::lsu_word_t resp_rdata [$]; // in-order responses
  logic               resp_err   [$];
  int                 resp_due   [$]; // model cycle of each rvalid
  lsu_pkg::lsu_word_t bus_rng = 32'hddfd;
  lsu_pkg::lsu_word_t rd_word;
  logic [13:0]        wa;
  int                 bus_cycle = 0;
  int                 due;
  int                 lane;

  always @(posedge clk) begin
    if (rst_n) begin
      bus_cycle++;
      if (data_req_o && data_gnt_i) begin
        wa = data_addr_o[13:0];
        if (data_we_o) begin
          for (lane = 0; lane < 4; lane++) begin
            if (data_be_o[lane]) bus_mem[wa + 14'(lane)] = data_wdata_o[8*lane +: 8];
          end
        end
        rd_word = {bus_mem[wa + 14'd3], bus_mem[wa + 14'd2],
                   bus_mem[wa + 14'd1], bus_mem[wa]};
        bus_rng = xorshift32(bus_rng);
        due     = bus_cycle + int'(bus_rng[1:0] % 3); // 0 to 2 extra cycles
        if (resp_due.size() > 0 && due <= resp_due[$]) due = resp_due[$] + 1;
        resp_rdata.push_back(rd_word);
        resp_err.push_back(data_addr_o[12]);          // error region
        resp_due.push_back(due);
      end
      bus_rng = xorshift32(bus_rng);
      if (resp_due.size() > 0 && resp_due[0] <= bus_cycle) begin
        data_rvalid_i <= 1'b1;
        data_rdata_i  <= resp_rdata.pop_front();
        data_err_i    <= resp_err.pop_front();
        void'(resp_due.pop_front());
      end else begin
        data_rvalid_i <= 1'b0;
        data_rdata_i  <= bus_rng;                     // junk between responses
        data_err_i    <= 1'b0;
      end
      data_gnt_i <= (resp_due.size() < 2) && (bus_rng[5:4] != 2'b00);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // protocol checks and timeout
  //////////////////////////////////////////////////////////////////////

  logic               req_seen = 1'b0;
  logic               stalled  = 1'b0; // request held without grant
  lsu_pkg::lsu_word_t held_addr;
  lsu_pkg::lsu_word_t held_wdata;
  lsu_pkg::lsu_be_t   held_be;
  int                 cycle_cnt = 0;

  always @(posedge clk) begin
    if (rst_n) begin
      if (lsu_req_i) req_seen = 1'b1;
      if (!req_seen) begin
        assert (!data_req_o && !lsu_valid_o && !busy_o)
          else value_error("DUT active after reset before any request");
      end
      if (data_req_o) begin
        assert (data_addr_o[1:0] == 2'b00)
          else value_error($sformatf("unaligned bus address %h", data_addr_o));
      end
      if (stalled) begin
        assert (data_req_o && data_addr_o == held_addr && data_be_o == held_be &&
                data_wdata_o == held_wdata)
          else value_error("bus request changed while waiting for grant");
      end
      stalled    = data_req_o && !data_gnt_i;
      held_addr  = data_addr_o;
      held_be    = data_be_o;
      held_wdata = data_wdata_o;
      if (lsu_valid_o) begin
        assert (lsu_req_i) else value_error("lsu_valid_o without a core request");
      end else begin
        assert (!load_err_o && !store_err_o)
          else value_error("error flag outside the lsu_valid_o cycle");
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout after %0d cycles, the access sequence did not finish",
                          cycle_cnt));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int                 n;
    lsu_pkg::lsu_word_t r;
    lsu_pkg::lsu_word_t stim_rng;
    lsu_req_i      = 1'b0;
    lsu_we_i       = 1'b0;
    lsu_sign_ext_i = 1'b0;
    lsu_type_i     = lsu_pkg::TYPE_WORD;
    lsu_addr_i     = '0;
    lsu_wdata_i    = '0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_err_i     = 1'b0;
    data_rdata_i   = '0;
    stim_rng       = 32'hddfd;
    for (n = 0; n < 16384; n++) begin
      bus_mem[n] = 8'(n ^ (n >> 6) ^ 8'h5a); // pattern over all 14 index bits
      ref_mem[n] = 8'(n ^ (n >> 6) ^ 8'h5a);
    end
    @(posedge clk);
    while (!rst_n) @(posedge clk);
    repeat (4) @(posedge clk);                 // quiet cycles after reset

    // aligned word round trip
    run_access(1'b1, lsu_pkg::TYPE_WORD, 1'b0, 32'h0000_0100, 32'hdead_beef);
    run_access(1'b0, lsu_pkg::TYPE_WORD, 1'b0, 32'h0000_0100, 32'h0);
    // byte and half loads with both extensions
    run_access(1'b1, lsu_pkg::TYPE_WORD, 1'b0, 32'h0000_0200, 32'h80ff_7f01);
    run_access(1'b0, lsu_pkg::TYPE_BYTE, 1'b1, 32'h0000_0200, 32'h0);
    run_access(1'b0, lsu_pkg::TYPE_BYTE, 1'b1, 32'h0000_0201, 32'h0);
    run_access(1'b0, lsu_pkg::TYPE_BYTE, 1'b1, 32'h0000_0202, 32'h0);
    run_access(1'b0, lsu_pkg::TYPE_BYTE, 1'b0, 32'h0000_0203, 32'h0);
    run_access(1'b0, lsu_pkg::TYPE_HALF, 1'b1, 32'h0000_0202, 32'h0);
    run_access(1'b0, lsu_pkg::TYPE_HALF, 1'b0, 32'h0000_0200, 32'h0);
    // split words and a half word at offset 3
    run_access(1'b1, lsu_pkg::TYPE_WORD, 1'b0, 32'h0000_0301, 32'h1122_3344);
    run_access(1'b0, lsu_pkg::TYPE_WORD, 1'b0, 32'h0000_0301, 32'h0);
    run_access(1'b0, lsu_pkg::TYPE_WORD, 1'b0, 32'h0000_0302, 32'h0);
    run_access(1'b1, lsu_pkg::TYPE_HALF, 1'b0, 32'h0000_0307, 32'h0000_a55a);
    run_access(1'b0, lsu_pkg::TYPE_HALF, 1'b1, 32'h0000_0307, 32'h0);
    // size code 3 behaves as byte
    run_access(1'b1, 2'd3, 1'b0, 32'h0000_030b, 32'h0000_00c3);
    run_access(1'b0, 2'd3, 1'b1, 32'h0000_030b, 32'h0);
    // bus errors in the whole access, the second part and the first part
    run_access(1'b0, lsu_pkg::TYPE_WORD, 1'b0, 32'h0000_1000, 32'h0);
    run_access(1'b1, lsu_pkg::TYPE_BYTE, 1'b0, 32'h0000_1005, 32'h0000_0077);
    run_access(1'b1, lsu_pkg::TYPE_WORD, 1'b0, 32'h0000_0ffe, 32'hcafe_f00d);
    run_access(1'b0, lsu_pkg::TYPE_WORD, 1'b0, 32'h0000_1ffd, 32'h0);
    run_access(1'b0, lsu_pkg::TYPE_HALF, 1'b0, 32'h0000_0fff, 32'h0);

    // random mix over two 256 byte windows with one in the error region
    for (n = 0; n < N_RANDOM; n++) begin
      stim_rng = xorshift32(stim_rng);
      r        = stim_rng;
      stim_rng = xorshift32(stim_rng);
      run_access(r[0], r[2:1], r[3], {19'd0, r[12], 4'd0, r[11:4]}, stim_rng);
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
//////////////////////////////////////////////////////////////////////
// testbench clock and reset source
// 40 ns clock, active low reset held for three cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o; // half of the 40 ns period
  end

  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_no <= 1'b1;             // released on the third rising edge
  end

endmodule

`default_nettype wire

// File: lsu_top.sv
//////////////////////////////////////////////////////////////////////
// load/store unit top level
// connects control FSM, store alignment and load alignment
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  var logic               clk_i,
  input  var logic               rst_ni,
  // core side
  input  var logic               lsu_req_i,
  input  var logic               lsu_we_i,
  input  var logic               lsu_sign_ext_i,
  input  var lsu_pkg::lsu_type_t lsu_type_i,
  input  var lsu_pkg::lsu_word_t lsu_addr_i,
  input  var lsu_pkg::lsu_word_t lsu_wdata_i,
  output lsu_pkg::lsu_word_t     lsu_rdata_o,
  output logic                   lsu_valid_o,
  output logic                   addr_incr_req_o,
  output logic                   load_err_o,
  output logic                   store_err_o,
  output logic                   busy_o,
  // data bus
  output logic                   data_req_o,
  input  var logic               data_gnt_i,
  input  var logic               data_rvalid_i,
  input  var logic               data_err_i,
  input  var lsu_pkg::lsu_word_t data_rdata_i,
  output logic                   data_we_o,
  output lsu_pkg::lsu_word_t     data_addr_o,
  output lsu_pkg::lsu_word_t     data_wdata_o,
  output lsu_pkg::lsu_be_t       data_be_o
);

  lsu_pkg::lsu_offset_t addr_offset; // same for both parts of a split
  logic                 ctrl_update;
  logic                 rdata_update;
  logic                 second_part;

  assign addr_offset = lsu_addr_i[1:0];
  assign data_addr_o = {lsu_addr_i[31:2], 2'b00}; // bus sees word addresses only
  assign data_we_o   = lsu_we_i;

  lsu_ctrl_fsm u_ctrl_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lsu_req_i       (lsu_req_i),
    .lsu_we_i        (lsu_we_i),
    .lsu_type_i      (lsu_type_i),
    .addr_offset_i   (addr_offset),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_err_i      (data_err_i),
    .data_req_o      (data_req_o),
    .lsu_valid_o     (lsu_valid_o),
    .addr_incr_req_o (addr_incr_req_o),
    .ctrl_update_o   (ctrl_update),
    .rdata_update_o  (rdata_update),
    .second_part_o   (second_part),
    .load_err_o      (load_err_o),
    .store_err_o     (store_err_o),
    .busy_o          (busy_o)
  );

  lsu_store_align u_store_align (
    .lsu_type_i    (lsu_type_i),
    .addr_offset_i (addr_offset),
    .second_part_i (second_part),
    .wdata_i       (lsu_wdata_i),
    .be_o          (data_be_o),
    .wdata_o       (data_wdata_o)
  );

  lsu_load_align u_load_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .addr_offset_i  (addr_offset),
    .lsu_type_i     (lsu_type_i),
    .sign_ext_i     (lsu_sign_ext_i),
    .bus_rdata_i    (data_rdata_i),
    .rdata_o        (lsu_rdata_o)
  );

endmodule

`default_nettype wire

// File: lsu_ctrl_fsm.sv
//////////////////////////////////////////////////////////////////////
// load/store transaction control
// bus request FSM, misaligned split detection and error merging
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl_fsm (
  input  var logic                 clk_i,
  input  var logic                 rst_ni,
  input  var logic                 lsu_req_i,
  input  var logic                 lsu_we_i,
  input  var lsu_pkg::lsu_type_t   lsu_type_i,
  input  var lsu_pkg::lsu_offset_t addr_offset_i,
  input  var logic                 data_gnt_i,
  input  var logic                 data_rvalid_i,
  input  var logic                 data_err_i,
  output logic                     data_req_o,
  output logic                     lsu_valid_o,
  output logic                     addr_incr_req_o,
  output logic                     ctrl_update_o,  // latch access controls
  output logic                     rdata_update_o, // capture first load word
  output logic                     second_part_o,  // second word on the bus
  output logic                     load_err_o,
  output logic                     store_err_o,
  output logic                     busy_o
);

  typedef enum logic [2:0] {
    IDLE,             // no access in flight
    WAIT_GNT_MIS,     // first part of a split waits for grant
    WAIT_RVALID_MIS,  // first part granted and second part requested
    WAIT_GNT,         // single or second part waits for grant
    WAIT_RVALID,      // last response outstanding
    WAIT_RVALID_DONE  // both granted with the first response still due
  } lsu_state_e;

  lsu_state_e state_q, state_d;

  logic split_access;              // access needs two bus words
  logic split_q, split_d;          // second part in progress
  logic err_q, err_d;              // first part came back with an error
  logic we_q;                      // write enable of the current access
  logic err_final;                 // error of either part in the valid cycle

  assign split_access =
      ((lsu_type_i == lsu_pkg::TYPE_WORD) && (addr_offset_i != 2'd0)) ||
      ((lsu_type_i == lsu_pkg::TYPE_HALF) && (addr_offset_i == 2'd3));

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    split_d         = split_q;
    err_d           = err_q;
    data_req_o      = 1'b0;
    lsu_valid_o     = 1'b0;
    addr_incr_req_o = 1'b0;
    ctrl_update_o   = 1'b0;
    rdata_update_o  = 1'b0;
    err_final       = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;   // straight from the core request
          err_d      = 1'b0;
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            split_d       = split_access;
            state_d       = split_access ? WAIT_RVALID_MIS : WAIT_RVALID;
          end else begin
            state_d       = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;     // hold first part until accepted
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          split_d       = 1'b1;
          state_d       = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        data_req_o      = 1'b1; // second part goes out at once
        addr_incr_req_o = 1'b1; // core moves to the next word
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          rdata_update_o = ~we_q;
          state_d        = data_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end else if (data_gnt_i) begin
          state_d        = WAIT_RVALID_DONE; // two responses now pending
        end
      end

      WAIT_GNT: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = split_q; // only set for a second part
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          state_d       = WAIT_RVALID;
        end
      end

      WAIT_RVALID: begin
        if (data_rvalid_i) begin
          lsu_valid_o = 1'b1;
          err_final   = err_q | data_err_i; // merge both parts
          split_d     = 1'b0;
          state_d     = IDLE;
        end
      end

      WAIT_RVALID_DONE: begin
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          rdata_update_o = ~we_q;
          state_d        = WAIT_RVALID;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      split_q <= 1'b0;
      err_q   <= 1'b0;
      we_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      split_q <= split_d;
      err_q   <= err_d;
      if (ctrl_update_o) begin
        we_q <= lsu_we_i;    // decides load vs store error
      end
    end
  end

  assign second_part_o = split_q;
  assign load_err_o    = err_final & ~we_q;
  assign store_err_o   = err_final & we_q;
  assign busy_o        = (state_q != IDLE);

endmodule

`default_nettype wire

// File: lsu_load_align.sv
//////////////////////////////////////////////////////////////////////
// load path alignment
// access control latch, first-word capture for split loads,
// word realignment and zero or sign extension
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
  input  var logic                 clk_i,
  input  var logic                 rst_ni,
  input  var logic                 ctrl_update_i,  // grant seen, latch controls
  input  var logic                 rdata_update_i, // first half of a split load back
  input  var lsu_pkg::lsu_offset_t addr_offset_i,
  input  var lsu_pkg::lsu_type_t   lsu_type_i,
  input  var logic                 sign_ext_i,
  input  var lsu_pkg::lsu_word_t   bus_rdata_i,
  output lsu_pkg::lsu_word_t       rdata_o
);

  logic [31:8]          rdata_q;     // upper three bytes of first bus word
  lsu_pkg::lsu_offset_t offset_q;
  lsu_pkg::lsu_type_t   type_q;
  logic                 sign_ext_q;

  lsu_pkg::lsu_word_t   rdata_w;     // realigned word
  lsu_pkg::lsu_word_t   rdata_rot;   // bus word shifted down by the offset
  logic [15:0]          rdata_h;     // selected half word
  logic [7:0]           rdata_b;     // selected byte

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  // controls for the response, taken when the request is granted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= '0;
      type_q     <= lsu_pkg::TYPE_WORD;
      sign_ext_q <= 1'b0;
    end else if (ctrl_update_i) begin
      offset_q   <= addr_offset_i;
      type_q     <= lsu_type_i;
      sign_ext_q <= sign_ext_i;
    end
  end

  // lane 0 of the first word never belongs to a split result
  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= bus_rdata_i[31:8];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // realignment
  //////////////////////////////////////////////////////////////////////

  // result byte k is memory byte offset+k, bytes past lane 3 come
  // from the word currently on the bus
  always_comb begin
    unique case (offset_q)
      2'd0:    rdata_w = bus_rdata_i;
      2'd1:    rdata_w = {bus_rdata_i[7:0],  rdata_q[31:8]};
      2'd2:    rdata_w = {bus_rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w = {bus_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  assign rdata_rot = bus_rdata_i >> {offset_q, 3'b000}; // unsplit half or byte

  // only a half word at offset 3 spans two bus words
  assign rdata_h = (offset_q == 2'd3) ? rdata_w[15:0] : rdata_rot[15:0];
  assign rdata_b = rdata_rot[7:0];

  //////////////////////////////////////////////////////////////////////
  // extension and size select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (type_q)
      lsu_pkg::TYPE_WORD: rdata_o = rdata_w;
      lsu_pkg::TYPE_HALF: rdata_o = {{16{sign_ext_q & rdata_h[15]}}, rdata_h};
      lsu_pkg::TYPE_BYTE: rdata_o = {{24{sign_ext_q & rdata_b[7]}}, rdata_b};
      default:            rdata_o = {{24{sign_ext_q & rdata_b[7]}}, rdata_b}; // code 3
    endcase
  end

endmodule

`default_nettype wire

// File: lsu_store_align.sv
//////////////////////////////////////////////////////////////////////
// store path alignment
// byte-enable generation and rotation of write data onto bus lanes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_store_align (
  input  var lsu_pkg::lsu_type_t   lsu_type_i,    // access size
  input  var lsu_pkg::lsu_offset_t addr_offset_i, // low address bits
  input  var logic                 second_part_i, // second word of a split
  input  var lsu_pkg::lsu_word_t   wdata_i,       // operand from the core
  output lsu_pkg::lsu_be_t         be_o,
  output lsu_pkg::lsu_word_t       wdata_o
);

  lsu_pkg::lsu_be_t word_mask; // word enables from the offset up
  lsu_pkg::lsu_be_t half_mask; // two lanes from the offset, clipped
  lsu_pkg::lsu_be_t byte_mask; // single lane at the offset

  // masks shifted left by the offset, upper lanes drop off the word
  assign word_mask = lsu_pkg::lsu_be_t'(4'b1111 << addr_offset_i);
  assign half_mask = lsu_pkg::lsu_be_t'(4'b0011 << addr_offset_i);
  assign byte_mask = lsu_pkg::lsu_be_t'(4'b0001 << addr_offset_i);

  //////////////////////////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (lsu_type_i)
      lsu_pkg::TYPE_WORD: begin
        if (!second_part_i) begin
          be_o = word_mask;  // 1111, 1110, 1100, 1000
        end else begin
          be_o = ~word_mask; // leftover low lanes of the next word
        end
      end
      lsu_pkg::TYPE_HALF: begin
        if (!second_part_i) begin
          be_o = half_mask;  // offset 3 keeps only lane 3
        end else begin
          be_o = 4'b0001;    // upper byte lands in lane 0
        end
      end
      default: begin
        be_o = byte_mask;    // bytes are never split
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // write data rotation
  //////////////////////////////////////////////////////////////////////

  // operand byte k goes to lane (offset + k) mod 4
  // same rotation serves both parts of a split access
  always_comb begin
    unique case (addr_offset_i)
      2'd0:    wdata_o = wdata_i;
      2'd1:    wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'd2:    wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

endmodule

`default_nettype wire

// File: lsu_pkg.sv
//////////////////////////////////////////////////////////////////////
// load/store unit shared types
// word, byte-enable, offset and access-size types plus size codes
//////////////////////////////////////////////////////////////////////

`default_nettype none

package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] lsu_word_t;   // data or address word
  typedef logic [3:0]  lsu_be_t;     // one enable per byte lane
  typedef logic [1:0]  lsu_offset_t; // byte position inside a word
  typedef logic [1:0]  lsu_type_t;   // access size code

  //////////////////////////////////////////////////////////////////////
  // access size codes
  //////////////////////////////////////////////////////////////////////

  // code 3 is decoded as a byte access everywhere
  localparam lsu_type_t TYPE_WORD = 2'd0; // 32 bit
  localparam lsu_type_t TYPE_HALF = 2'd1; // 16 bit
  localparam lsu_type_t TYPE_BYTE = 2'd2; // 8 bit

endpackage

`default_nettype wire
